// File: project.f
+incdir+include
source/dac_cfg_pkg.sv
source/cfg_capture.sv
source/step_sequencer.sv
source/cmd_table.sv
source/dac_reg_config.sv
verification/tb_dac_reg_config.sv

// File: Bender.yml
package:
  name: dac_reg_config

sources:
  # Package first, then the stages and the top level
  - files:
      - source/dac_cfg_pkg.sv
      - source/cfg_capture.sv
      - source/step_sequencer.sv
      - source/cmd_table.sv
      - source/dac_reg_config.sv

  - target: test
    include_dirs:
      - include
    files:
      - verification/tb_dac_reg_config.sv

// File: include/dac_cfg_model.svh
`ifndef DAC_CFG_MODEL_SVH
`define DAC_CFG_MODEL_SVH

// Expected words, one per step, in issue order
typedef dac_cfg_pkg::cfg_word_t model_list_t [dac_cfg_pkg::NUM_STEPS];

function automatic model_list_t build_expected(
    input dac_cfg_pkg::user_words_t uw,
    input dac_cfg_pkg::ftw_t        f
);
    model_list_t exp_list;
    int          idx;

    idx = 0;
    exp_list[idx] = {1'b0, 7'h00, 8'h20};  // Soft reset set
    idx++;
    exp_list[idx] = {1'b0, 7'h00, 8'h00};
    idx++;

    for (int i = 0; i < dac_cfg_pkg::NUM_USER_WORDS; i++) begin
        exp_list[idx] = uw[i];
        idx++;
    end

    // Tuning word bytes, LSB at 0x30
    for (int b = 0; b < 4; b++) begin
        exp_list[idx] = {f.rw, 7'(7'h30 + b), f.value[b*8 +: 8]};
        idx++;
    end

    exp_list[idx] = {1'b0, 7'h36, 8'h01};
    idx++;
    exp_list[idx] = {1'b0, 7'h36, 8'h00};

    return exp_list;
endfunction

`endif

// File: verification/tb_dac_reg_config.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dac_reg_config
    import dac_cfg_pkg::*;
;

    `include "dac_cfg_model.svh"

    localparam int unsigned DLY_CYCLES = 6;
    localparam int unsigned SET_CYCLES = 20;
    localparam int          SEQ_LIMIT  = 1000;  // Cycles allowed for one full sequence

    // DAC power-up tuning word, top byte 0x80
    localparam ftw_t POWERUP_FTW = '{rw: 1'b0, value: 32'h8000_0000};

    logic        clk;
    logic        rst_r2;
    logic        para_en;
    user_words_t user_words_in;
    ftw_t        ftw_in;
    spi_out_t    spi;

    int          seed = 32'hd40;
    cfg_word_t   starts[$];
    int          start_cycles[$];
    int          cycle = 0;
    string       cur_test;
    int          test_errors;
    int          total_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    dac_reg_config #(
        .DLY_CYCLES (DLY_CYCLES),
        .SET_CYCLES (SET_CYCLES)
    ) i_dac_reg_config (
        .clk           (clk),
        .rst_r2        (rst_r2),
        .para_en       (para_en),
        .user_words_in (user_words_in),
        .ftw_in        (ftw_in),
        .spi           (spi)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Flop outputs read at the edge, before they update
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (spi.start === 1'b1) begin
            starts.push_back(spi.word);
            start_cycles.push_back(cycle);
        end
    end

    ////////////////////////////////////////
    // Check helpers
    ////////////////////////////////////////

    task automatic begin_test(input string name);
        cur_test    = name;
        test_errors = 0;
        tests_run++;
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            $display("Test %s: PASS", cur_test);
        end else begin
            $display("Test %s: FAIL (%0d errors)", cur_test, test_errors);
            tests_failed++;
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else begin
            $display("** Error: %s %s expected %0h actual %0h", cur_test, what, exp, got);
            test_errors++;
            total_errors++;
        end
    endtask

    task automatic wait_for_starts(input int n, input int limit);
        int waited;
        waited = 0;
        while (starts.size() < n && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        assert (starts.size() >= n) else begin
            $display("Test %s: timed out after %0d cycles waiting for start pulse %0d",
                     cur_test, limit, n);
            test_errors++;
            total_errors++;
        end
    endtask

    // New values valid only around the falling edge of para_en
    task automatic pulse_para_en(input user_words_t uw, input ftw_t f, input int high_cycles);
        @(negedge clk);
        para_en = 1'b1;
        @(negedge clk);
        user_words_in = uw;
        ftw_in        = f;
        repeat (high_cycles - 1) @(negedge clk);
        para_en = 1'b0;
        starts.delete();
        start_cycles.delete();
        @(negedge clk);
        user_words_in = ~uw;  // Past the capture edge
        ftw_in        = ~f;
    endtask

    task automatic compare_sequence(input model_list_t exp_list);
        check_value("start count", 32'(NUM_STEPS), 32'(starts.size()));
        for (int i = 0; i < NUM_STEPS; i++) begin
            check_value($sformatf("word %0d", i), 32'(exp_list[i]), 32'(starts[i]));
        end
    endtask

    task automatic random_values(output user_words_t uw, output ftw_t f);
        for (int i = 0; i < NUM_USER_WORDS; i++) begin
            uw[i] = 16'($random(seed));
        end
        f.value = $random(seed);
        f.rw    = 1'($random(seed));
    endtask

    // Power-up user words in send order
    function automatic user_words_t default_user_words();
        logic [15:0] w [NUM_USER_WORDS];
        user_words_t uw;
        w = '{16'h0000, 16'h0000, 16'h0000, 16'h0000,
              16'h40F0, 16'h4101, 16'h44FF, 16'h4501,
              16'h0CD1, 16'h0DD6, 16'h0ACF, 16'h0AA0,
              16'h10C8, 16'h1704, 16'h1802, 16'h1800,
              16'h1B64, 16'h1C00, 16'h1D00, 16'h1E48};
        for (int i = 0; i < NUM_USER_WORDS; i++) begin
            uw[i] = w[i];
        end
        return uw;
    endfunction

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        user_words_t uw_a;
        user_words_t uw_b;
        ftw_t        f_a;
        ftw_t        f_b;

        rst_r2        = 1'b1;
        para_en       = 1'b0;
        user_words_in = '0;
        ftw_in        = '0;
        repeat (5) @(negedge clk);
        rst_r2 = 1'b0;

        begin_test("reset_defaults");
        wait_for_starts(NUM_STEPS, SEQ_LIMIT);
        compare_sequence(build_expected(default_user_words(), POWERUP_FTW));
        end_test();

        begin_test("random_update");
        random_values(uw_a, f_a);
        pulse_para_en(uw_a, f_a, 3);
        wait_for_starts(NUM_STEPS, SEQ_LIMIT);
        compare_sequence(build_expected(uw_a, f_a));
        for (int b = 0; b < 4; b++) begin
            check_value($sformatf("ftw byte %0d rw", b), 32'(f_a.rw), 32'(starts[22+b].rw));
            check_value($sformatf("ftw byte %0d addr", b), 32'(7'h30 + b),
                        32'(starts[22+b].addr));
        end
        check_value("update set word", 32'h3601, 32'(starts[26]));
        check_value("update clear word", 32'h3600, 32'(starts[27]));
        end_test();

        // Uses the sequence just recorded
        begin_test("start_spacing");
        check_value("gap 0 to 1", SET_CYCLES + 1, 32'(start_cycles[1] - start_cycles[0]));
        for (int i = 2; i < NUM_STEPS; i++) begin
            check_value($sformatf("gap %0d to %0d", i - 1, i), DLY_CYCLES + 1,
                        32'(start_cycles[i] - start_cycles[i-1]));
        end
        end_test();

        begin_test("abort_restart");
        random_values(uw_a, f_a);
        random_values(uw_b, f_b);
        pulse_para_en(uw_a, f_a, 2);
        wait_for_starts(5, SEQ_LIMIT);
        pulse_para_en(uw_b, f_b, 4);  // Lands in the middle of the user words
        wait_for_starts(NUM_STEPS, SEQ_LIMIT);
        check_value("first word after abort", 32'h0020, 32'(starts[0]));
        compare_sequence(build_expected(uw_b, f_b));
        end_test();

        begin_test("idle_after_done");
        repeat (4 * (SET_CYCLES + 1)) @(negedge clk);
        check_value("start count", 32'(NUM_STEPS), 32'(starts.size()));
        check_value("spi word", 32'h0, 32'(spi.word));
        end_test();

        $display("Tests run: %0d, failed: %0d, check errors: %0d",
                 tests_run, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/dac_reg_config.sv
`timescale 1ns/1ps
`default_nettype none

module dac_reg_config
    import dac_cfg_pkg::*;
#(
    parameter int unsigned DLY_CYCLES = 10000,
    parameter int unsigned SET_CYCLES = 200000000
) (
    input  logic        clk,
    input  logic        rst_r2,
    input  logic        para_en,
    input  user_words_t user_words_in,
    input  ftw_t        ftw_in,
    output spi_out_t    spi
);

    user_words_t user_words;
    ftw_t        ftw;
    logic        seq_restart;
    cmd_issue_t  cmd;

    // Capture stage
    cfg_capture i_cfg_capture (
        .clk           (clk),
        .rst_r2        (rst_r2),
        .para_en       (para_en),
        .user_words_in (user_words_in),
        .ftw_in        (ftw_in),
        .user_words    (user_words),
        .ftw           (ftw),
        .seq_restart   (seq_restart)
    );

    step_sequencer #(
        .DLY_CYCLES (DLY_CYCLES),
        .SET_CYCLES (SET_CYCLES)
    ) i_step_sequencer (
        .clk         (clk),
        .rst_r2      (rst_r2),
        .seq_restart (seq_restart),
        .cmd         (cmd)
    );

    // Command formation, one cycle behind the sequencer
    cmd_table i_cmd_table (
        .clk        (clk),
        .rst_r2     (rst_r2),
        .cmd        (cmd),
        .user_words (user_words),
        .ftw        (ftw),
        .spi        (spi)
    );

endmodule

`default_nettype wire

// File: source/cmd_table.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_table
    import dac_cfg_pkg::*;
(
    input  logic        clk,
    input  logic        rst_r2,
    input  cmd_issue_t  cmd,
    input  user_words_t user_words,
    input  ftw_t        ftw,
    output spi_out_t    spi
);

    cfg_word_t   word_next;
    logic [4:0]  user_idx;
    logic [1:0]  byte_idx;

    ////////////////////////////////////////
    // Step to command word
    ////////////////////////////////////////

    always_comb begin
        user_idx = cmd.step - STEP_USER_FIRST;
        byte_idx = 2'(cmd.step - STEP_FTW_FIRST);

        if (cmd.step == STEP_RST_SET) begin
            word_next = '{rw: 1'b0, addr: ADDR_RESET, data: RESET_SET_DATA};
        end else if (cmd.step == STEP_RST_CLR) begin
            word_next = '{rw: 1'b0, addr: ADDR_RESET, data: 8'h00};
        end else if (cmd.step <= STEP_USER_LAST) begin
            word_next = user_words[user_idx];
        end else if (cmd.step < STEP_FTW_UPD_SET) begin
            // Byte address follows the byte index, rw taken from bit 32
            word_next = '{rw:   ftw.rw,
                          addr: ADDR_FTW_BASE + 7'(byte_idx),
                          data: ftw.value[{byte_idx, 3'b000} +: 8]};
        end else if (cmd.step == STEP_FTW_UPD_SET) begin
            word_next = '{rw: 1'b0, addr: ADDR_FTW_UPDATE, data: FTW_UPDATE_BIT};
        end else if (cmd.step == STEP_FTW_UPD_CLR) begin
            word_next = '{rw: 1'b0, addr: ADDR_FTW_UPDATE, data: 8'h00};
        end else begin
            word_next = '0;
        end
    end

    ////////////////////////////////////////
    // SPI output register
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_r2) begin
            spi.start <= 1'b0;
            spi.word  <= '0;
        end else begin
            spi.start <= cmd.issue;
            if (cmd.issue) begin
                spi.word <= word_next;
            end else if (cmd.step == NUM_STEPS) begin
                spi.word <= '0;  // Sequence finished
            end
        end
    end

    // Steps are always spaced by more than one cycle
    start_is_pulse: assert property (
        @(posedge clk) disable iff (rst_r2)
        spi.start |=> !spi.start
    );

endmodule

`default_nettype wire

// File: source/step_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module step_sequencer
    import dac_cfg_pkg::*;
#(
    parameter int unsigned DLY_CYCLES = 10000,
    parameter int unsigned SET_CYCLES = 200000000
) (
    input  logic       clk,
    input  logic       rst_r2,
    input  logic       seq_restart,
    output cmd_issue_t cmd
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_RUN,
        S_DONE
    } state_t;

    state_t      state;
    logic [31:0] timer;
    logic [31:0] limit;
    step_t       step;

    // Soft reset needs the long settle
    always_comb begin
        if (step == STEP_RST_SET) begin
            limit = 32'(SET_CYCLES);
        end else begin
            limit = 32'(DLY_CYCLES);
        end
    end

    ////////////////////////////////////////
    // Step FSM
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_r2 || seq_restart) begin
            state <= S_IDLE;
            timer <= '0;
            step  <= STEP_RST_SET;
        end else begin
            case (state)
                S_IDLE: begin
                    if (timer == 32'(DLY_CYCLES)) begin
                        timer <= '0;
                        state <= S_RUN;
                    end else begin
                        timer <= timer + 32'd1;
                    end
                end
                S_RUN: begin
                    if (timer == limit) begin
                        timer <= '0;
                        step  <= step + 5'd1;  // Wraps to NUM_STEPS at the end
                        if (step == STEP_FTW_UPD_CLR) begin
                            state <= S_DONE;
                        end
                    end else begin
                        timer <= timer + 32'd1;
                    end
                end
                S_DONE: begin
                    timer <= '0;  // Parked until the next restart
                end
                default: begin
                    state <= S_IDLE;
                    timer <= '0;
                    step  <= STEP_RST_SET;
                end
            endcase
        end
    end

    // Second cycle of each step
    assign cmd.issue = (state == S_RUN) && (timer == 32'd1);
    assign cmd.step  = step;

    issue_step_in_range: assert property (
        @(posedge clk) disable iff (rst_r2)
        cmd.issue |-> (cmd.step < NUM_STEPS)
    );

endmodule

`default_nettype wire

// File: source/cfg_capture.sv
`timescale 1ns/1ps
`default_nettype none

module cfg_capture
    import dac_cfg_pkg::*;
(
    input  logic        clk,
    input  logic        rst_r2,
    input  logic        para_en,
    input  user_words_t user_words_in,
    input  ftw_t        ftw_in,
    output user_words_t user_words,
    output ftw_t        ftw,
    output logic        seq_restart
);

    logic para_en_d;
    logic para_fall;

    assign para_fall = para_en_d & ~para_en;

    ////////////////////////////////////////
    // Update detection
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_r2) begin
            para_en_d <= 1'b0;
        end else begin
            para_en_d <= para_en;
        end
    end

    // Holds the sequencer off while reset or an update is in progress
    always_ff @(posedge clk) begin
        seq_restart <= rst_r2 | para_en;
    end

    ////////////////////////////////////////
    // Shadow registers
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_r2) begin
            user_words <= DEFAULT_USER_WORDS;
            ftw        <= DEFAULT_FTW;
        end else if (para_fall) begin
            user_words <= user_words_in;  // Loaded as the restart is released
            ftw        <= ftw_in;
        end
    end

endmodule

`default_nettype wire

// File: source/dac_cfg_pkg.sv
`default_nettype none

package dac_cfg_pkg;

    ////////////////////////////////////////
    // Command word and payload types
    ////////////////////////////////////////

    localparam int NUM_USER_WORDS = 20;

    // One SPI command, rw 0 is a write
    typedef struct packed {
        logic       rw;
        logic [6:0] addr;
        logic [7:0] data;
    } cfg_word_t;

    typedef cfg_word_t [NUM_USER_WORDS-1:0] user_words_t;  // Index 0 goes out first

    typedef struct packed {
        logic        rw;     // Shared by all four byte writes
        logic [31:0] value;
    } ftw_t;

    typedef logic [4:0] step_t;

    ////////////////////////////////////////
    // Step numbering
    ////////////////////////////////////////

    localparam step_t STEP_RST_SET     = 5'd0;
    localparam step_t STEP_RST_CLR     = 5'd1;
    localparam step_t STEP_USER_FIRST  = 5'd2;
    localparam step_t STEP_USER_LAST   = 5'd21;
    localparam step_t STEP_FTW_FIRST   = 5'd22;  // LSB first
    localparam step_t STEP_FTW_UPD_SET = 5'd26;
    localparam step_t STEP_FTW_UPD_CLR = 5'd27;
    localparam step_t NUM_STEPS        = 5'd28;

    // DAC register map
    localparam logic [6:0] ADDR_RESET      = 7'h00;
    localparam logic [6:0] ADDR_FTW_BASE   = 7'h30;
    localparam logic [6:0] ADDR_FTW_UPDATE = 7'h36;

    localparam logic [7:0] RESET_SET_DATA = 8'h20;  // Soft reset bit
    localparam logic [7:0] FTW_UPDATE_BIT = 8'h01;

    // Last word on the left
    localparam user_words_t DEFAULT_USER_WORDS = {
        16'h1E48, 16'h1D00, 16'h1C00, 16'h1B64,
        16'h1800, 16'h1802, 16'h1704, 16'h10C8,
        16'h0AA0, 16'h0ACF, 16'h0DD6, 16'h0CD1,
        16'h4501, 16'h44FF, 16'h4101, 16'h40F0,
        16'h0000, 16'h0000, 16'h0000, 16'h0000
    };

    localparam ftw_t DEFAULT_FTW = '{rw: 1'b0, value: 32'h8000_0000};

    // Sequencer to command table
    typedef struct packed {
        logic  issue;
        step_t step;
    } cmd_issue_t;

    typedef struct packed {
        logic      start;
        cfg_word_t word;
    } spi_out_t;

endpackage

`default_nettype wire
